/* build.f */
src/decode_pkg.sv
src/instr_fields.sv
src/operand_fetch.sv
src/issue_ctrl.sv
src/dispatch_regs.sv
src/i_decode_top.sv
verif/tb_clkgen.sv
verif/tb_i_decode.sv

/* verif/tb_i_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_i_decode import decode_pkg::*; ();

    // all tests finish well inside this
    localparam int TIMEOUT_CYCLES = 400;

    logic clk;
    logic rst_n_i;
    logic flush_i;
    word_t instr_i;
    word_t pc_i;
    logic i_queue_empty_i;
    logic i_queue_read_o;
    word_t reg_vj_i;
    word_t reg_vk_i;
    rob_tag_t reg_qj_i;
    rob_tag_t reg_qk_i;
    reg_idx_t rs1_o;
    reg_idx_t rs2_o;
    reg_idx_t rd_o;
    rob_tag_t tag_o;
    logic tag_load_o;
    rob_tag_t rob_free_tag_i;
    logic rob_full_i;
    logic [ROB_DEPTH-1:0] rob_ready_i;
    word_t [ROB_DEPTH-1:0] rob_value_i;
    logic rob_write_o;
    word_t rob_pc_o;
    opcode_t rob_opcode_o;
    reg_idx_t rob_rd_o;
    logic alu_rs_full_i;
    logic alu_valid_o;
    alu_op_t alu_op_o;
    operand_t alu_src1_o;
    operand_t alu_src2_o;
    rob_tag_t alu_rob_tag_o;
    logic cmp_rs_full_i;
    logic cmp_valid_o;
    cmp_op_t cmp_op_o;
    logic cmp_is_branch_o;
    operand_t cmp_src1_o;
    operand_t cmp_src2_o;
    word_t cmp_pc_o;
    word_t cmp_b_imm_o;
    rob_tag_t cmp_rob_tag_o;

    integer seed;
    int errors;
    int cycles;
    string cur_test;
    word_t pc_base;

    // register file stub answers rs1/rs2 in the same cycle
    word_t reg_vals [32];
    rob_tag_t reg_tags [32];

    assign reg_vj_i = reg_vals[rs1_o];
    assign reg_vk_i = reg_vals[rs2_o];
    assign reg_qj_i = reg_tags[rs1_o];
    assign reg_qk_i = reg_tags[rs2_o];

    tb_clkgen u_clkgen (
        .clk_o (clk)
    );

    i_decode_top u_dut (.*);

    function automatic operand_t opnd(input word_t v, input rob_tag_t t, input logic r);
        operand_t op;
        op.value = v;
        op.tag   = t;
        op.ready = r;
        return op;
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_i(input word_t imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // branch offset scrambled as imm[12|10:5] and imm[4:1|11]
    function automatic word_t enc_b(input word_t off, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: %s is %b, expected %b", $time, cur_test, what, got, exp);
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: %s is %h, expected %h", $time, cur_test, what, got, exp);
        end
    endtask

    task automatic check_tag(input rob_tag_t got, input rob_tag_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: %s is %0d, expected %0d", $time, cur_test, what, got, exp);
        end
    endtask

    task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: %s is x%0d, expected x%0d", $time, cur_test, what, got, exp);
        end
    endtask

    task automatic check_alu_op(input alu_op_t got, input alu_op_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: %s is %b, expected %b", $time, cur_test, what, got, exp);
        end
    endtask

    task automatic check_cmp_op(input cmp_op_t got, input cmp_op_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: %s is %b, expected %b", $time, cur_test, what, got, exp);
        end
    endtask

    task automatic check_opcode(input opcode_t got, input opcode_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: %s is %b, expected %b", $time, cur_test, what, got, exp);
        end
    endtask

    task automatic check_operand(input operand_t got, input operand_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: %s is %h/%0d/%b, expected %h/%0d/%b", $time, cur_test,
                     what, got.value, got.tag, got.ready, exp.value, exp.tag, exp.ready);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic present(input word_t instr, input word_t pc, input rob_tag_t tag);
        instr_i         = instr;
        pc_i            = pc;
        rob_free_tag_i  = tag;
        i_queue_empty_i = 1'b0;
    endtask

    task automatic go_idle();
        i_queue_empty_i = 1'b1;
        instr_i         = '0;
    endtask

    // accept then one cycle of alu_valid_o and an idle cycle
    task automatic send_alu(input word_t instr, input word_t pc, input rob_tag_t tag,
                            input reg_idx_t rd, input alu_op_t op,
                            input operand_t s1, input operand_t s2);
        present(instr, pc, tag);
        #2;
        check_bit(i_queue_read_o, 1'b1, "i_queue_read_o");
        check_bit(tag_load_o, 1'b1, "tag_load_o");
        check_tag(tag_o, tag, "tag_o");
        check_idx(rd_o, rd, "rd_o");
        next_cycle();
        go_idle();
        check_bit(alu_valid_o, 1'b1, "alu_valid_o");
        check_bit(cmp_valid_o, 1'b0, "cmp_valid_o");
        check_bit(rob_write_o, 1'b1, "rob_write_o");
        check_alu_op(alu_op_o, op, "alu_op_o");
        check_operand(alu_src1_o, s1, "alu_src1_o");
        check_operand(alu_src2_o, s2, "alu_src2_o");
        check_tag(alu_rob_tag_o, tag, "alu_rob_tag_o");
        check_word(rob_pc_o, pc, "rob_pc_o");
        check_opcode(rob_opcode_o, opcode_t'(instr[6:0]), "rob_opcode_o");
        check_idx(rob_rd_o, rd, "rob_rd_o");
        next_cycle();
        check_bit(alu_valid_o, 1'b0, "alu_valid_o after one cycle");
        check_bit(rob_write_o, 1'b0, "rob_write_o after one cycle");
    endtask

    task automatic send_cmp(input word_t instr, input word_t pc, input rob_tag_t tag,
                            input logic is_br, input reg_idx_t rob_rd, input cmp_op_t op,
                            input operand_t s1, input operand_t s2, input word_t b_imm);
        present(instr, pc, tag);
        #2;
        check_bit(i_queue_read_o, 1'b1, "i_queue_read_o");
        check_bit(tag_load_o, !is_br, "tag_load_o");
        if (!is_br) begin
            check_tag(tag_o, tag, "tag_o");
        end
        next_cycle();
        go_idle();
        check_bit(cmp_valid_o, 1'b1, "cmp_valid_o");
        check_bit(alu_valid_o, 1'b0, "alu_valid_o");
        check_bit(rob_write_o, 1'b1, "rob_write_o");
        check_cmp_op(cmp_op_o, op, "cmp_op_o");
        check_bit(cmp_is_branch_o, is_br, "cmp_is_branch_o");
        check_operand(cmp_src1_o, s1, "cmp_src1_o");
        check_operand(cmp_src2_o, s2, "cmp_src2_o");
        check_word(cmp_pc_o, pc, "cmp_pc_o");
        if (is_br) begin
            check_word(cmp_b_imm_o, b_imm, "cmp_b_imm_o");
        end
        check_tag(cmp_rob_tag_o, tag, "cmp_rob_tag_o");
        check_opcode(rob_opcode_o, opcode_t'(instr[6:0]), "rob_opcode_o");
        check_idx(rob_rd_o, rob_rd, "rob_rd_o");
        next_cycle();
        check_bit(cmp_valid_o, 1'b0, "cmp_valid_o after one cycle");
    endtask

    // stalled or discarded head gives no valid
    task automatic send_blocked(input word_t instr, input rob_tag_t tag, input logic exp_read);
        present(instr, pc_base, tag);
        #2;
        check_bit(i_queue_read_o, exp_read, "i_queue_read_o");
        check_bit(tag_load_o, 1'b0, "tag_load_o");
        next_cycle();
        go_idle();
        check_bit(alu_valid_o, 1'b0, "alu_valid_o");
        check_bit(cmp_valid_o, 1'b0, "cmp_valid_o");
        check_bit(rob_write_o, 1'b0, "rob_write_o");
    endtask

    task automatic alu_issue();
        cur_test = "alu issue";
        send_alu(enc_i(-5, 7, 3'b000, 3, op_imm), pc_base, 3'd1, 5'd3, alu_add,
                 opnd(reg_vals[7], 0, 1), opnd(-5, 0, 1));
        send_alu(enc_r(7'b0100000, 2, 1, 3'b000, 4), pc_base + 4, 3'd2, 5'd4, alu_sub,
                 opnd(reg_vals[1], 0, 1), opnd(reg_vals[2], 0, 1));
        send_alu(enc_i(32'h403, 6, 3'b101, 5, op_imm), pc_base + 8, 3'd3, 5'd5, alu_sra,
                 opnd(reg_vals[6], 0, 1), opnd(32'h403, 0, 1));
        send_alu(enc_u(20'habcde, 8, op_lui), pc_base + 12, 3'd4, 5'd8, alu_add,
                 opnd(0, 0, 1), opnd(32'habcde000, 0, 1));
        send_alu(enc_u(20'h12345, 9, op_auipc), pc_base + 16, 3'd7, 5'd9, alu_add,
                 opnd(pc_base + 16, 0, 1), opnd(32'h12345000, 0, 1));
    endtask

    task automatic compare_issue();
        cur_test = "compare issue";
        send_cmp(enc_b(-16, 2, 1, 3'b000), pc_base + 20, 3'd5, 1'b1, 5'd0, 3'b000,
                 opnd(reg_vals[1], 0, 1), opnd(reg_vals[2], 0, 1), -16);
        send_cmp(enc_i(100, 3, 3'b011, 10, op_imm), pc_base + 24, 3'd6, 1'b0, 5'd10, 3'b011,
                 opnd(reg_vals[3], 0, 1), opnd(100, 0, 1), '0);
    endtask

    task automatic operand_cases();
        word_t fwd;
        cur_test = "operand rule";
        fwd = $random(seed);
        // x13 waits on tag 5 and x14 is already done in ROB entry 6
        reg_tags[13]   = 3'd5;
        reg_tags[14]   = 3'd6;
        rob_ready_i[6] = 1'b1;
        rob_value_i[6] = fwd;
        send_alu(enc_r(7'b0, 13, 12, 3'b000, 11), pc_base + 28, 3'd1, 5'd11, alu_add,
                 opnd(reg_vals[12], 0, 1), opnd(0, 3'd5, 0));
        send_alu(enc_r(7'b0, 0, 14, 3'b000, 15), pc_base + 32, 3'd2, 5'd15, alu_add,
                 opnd(fwd, 0, 1), opnd(0, 0, 1));
        reg_tags[13]   = '0;
        reg_tags[14]   = '0;
        rob_ready_i[6] = 1'b0;
    endtask

    task automatic back_to_back();
        cur_test = "back to back";
        present(enc_r(7'b0, 2, 1, 3'b000, 5), pc_base + 36, 3'd3);
        next_cycle();
        present(enc_r(7'b0, 5, 5, 3'b000, 6), pc_base + 40, 3'd4);
        check_bit(alu_valid_o, 1'b1, "first alu_valid_o");
        check_tag(alu_rob_tag_o, 3'd3, "first alu_rob_tag_o");
        #2;
        check_idx(rs1_o, 5'd5, "second rs1_o");
        check_idx(rs2_o, 5'd5, "second rs2_o");
        check_bit(tag_load_o, 1'b1, "second tag_load_o");
        check_tag(tag_o, 3'd4, "second tag_o");
        next_cycle();
        go_idle();
        check_bit(alu_valid_o, 1'b1, "second alu_valid_o");
        check_tag(alu_rob_tag_o, 3'd4, "second alu_rob_tag_o");
        check_operand(alu_src1_o, opnd(0, 3'd3, 0), "second alu_src1_o");
        check_operand(alu_src2_o, opnd(0, 3'd3, 0), "second alu_src2_o");
        next_cycle();
        check_bit(alu_valid_o, 1'b0, "alu_valid_o after pair");
    endtask

    task automatic stall_and_discard();
        cur_test = "stall";
        alu_rs_full_i = 1'b1;
        send_blocked(enc_i(1, 7, 3'b000, 3, op_imm), 3'd1, 1'b0);
        // compare work still flows past a full alu station
        send_cmp(enc_i(9, 3, 3'b010, 12, op_imm), pc_base + 44, 3'd2, 1'b0, 5'd12, 3'b010,
                 opnd(reg_vals[3], 0, 1), opnd(9, 0, 1), '0);
        alu_rs_full_i = 1'b0;
        cmp_rs_full_i = 1'b1;
        send_blocked(enc_b(8, 2, 1, 3'b001), 3'd1, 1'b0);
        send_alu(enc_i(1, 7, 3'b000, 3, op_imm), pc_base + 48, 3'd3, 5'd3, alu_add,
                 opnd(reg_vals[7], 0, 1), opnd(1, 0, 1));
        cmp_rs_full_i = 1'b0;
        rob_full_i    = 1'b1;
        send_blocked(enc_i(1, 7, 3'b000, 3, op_imm), 3'd1, 1'b0);
        rob_full_i    = 1'b0;
        send_blocked(enc_i(1, 7, 3'b000, 3, op_imm), 3'd0, 1'b0);
        cur_test = "discard";
        send_blocked(enc_i(5, 1, 3'b000, 0, op_imm), 3'd1, 1'b1);
        // load opcode is not handled here
        send_blocked(enc_i(0, 1, 3'b010, 3, 7'b0000011), 3'd1, 1'b1);
    endtask

    task automatic flush_and_reset();
        cur_test = "flush";
        flush_i = 1'b1;
        send_blocked(enc_i(1, 7, 3'b000, 3, op_imm), 3'd1, 1'b0);
        flush_i = 1'b0;
        present(enc_r(7'b0, 2, 1, 3'b000, 5), pc_base + 52, 3'd3);
        next_cycle();
        flush_i = 1'b1;
        present(enc_r(7'b0, 5, 5, 3'b000, 6), pc_base + 56, 3'd4);
        #2;
        check_bit(i_queue_read_o, 1'b0, "i_queue_read_o under flush");
        check_bit(tag_load_o, 1'b0, "tag_load_o under flush");
        next_cycle();
        flush_i = 1'b0;
        go_idle();
        check_bit(alu_valid_o, 1'b0, "alu_valid_o after flush");
        check_bit(rob_write_o, 1'b0, "rob_write_o after flush");
        // with the rename record gone x5 comes from the register file again
        send_alu(enc_r(7'b0, 5, 5, 3'b000, 6), pc_base + 56, 3'd4, 5'd6, alu_add,
                 opnd(reg_vals[5], 0, 1), opnd(reg_vals[5], 0, 1));
        cur_test = "reset";
        present(enc_i(2, 7, 3'b000, 3, op_imm), pc_base + 60, 3'd2);
        next_cycle();
        go_idle();
        check_bit(alu_valid_o, 1'b1, "alu_valid_o before reset");
        rst_n_i = 1'b0;
        #1;
        check_bit(alu_valid_o, 1'b0, "alu_valid_o in reset");
        check_bit(cmp_valid_o, 1'b0, "cmp_valid_o in reset");
        check_bit(rob_write_o, 1'b0, "rob_write_o in reset");
        check_bit(i_queue_read_o, 1'b0, "i_queue_read_o in reset");
        check_bit(tag_load_o, 1'b0, "tag_load_o in reset");
        next_cycle();
        next_cycle();
        rst_n_i = 1'b1;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout hit after %0d cycles, %0d errors so far", cycles, errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        seed            = 32'hb7b16bf6;
        errors          = 0;
        cycles          = 0;
        cur_test        = "init";
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        instr_i         = '0;
        pc_i            = '0;
        i_queue_empty_i = 1'b1;
        rob_free_tag_i  = 3'd1;
        rob_full_i      = 1'b0;
        rob_ready_i     = '0;
        rob_value_i     = '0;
        alu_rs_full_i   = 1'b0;
        cmp_rs_full_i   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            reg_vals[i] = $random(seed);
            reg_tags[i] = '0;
        end
        reg_vals[0] = '0;
        pc_base = $random(seed);
        pc_base = pc_base & 32'hffff_fffc;

        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        cur_test = "after reset";
        check_bit(alu_valid_o, 1'b0, "alu_valid_o");
        check_bit(cmp_valid_o, 1'b0, "cmp_valid_o");
        check_bit(rob_write_o, 1'b0, "rob_write_o");
        check_bit(i_queue_read_o, 1'b0, "i_queue_read_o");
        check_bit(tag_load_o, 1'b0, "tag_load_o");

        alu_issue();
        compare_issue();
        operand_cases();
        back_to_back();
        stall_and_discard();
        flush_and_reset();

        $display("tests done after %0d cycles, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic clk_o
);

    // 8 ns period
    localparam time HALF_PERIOD = 4ns;

    initial begin
        clk_o = 1'b0;
    end

    always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* src/i_decode_top.sv */
`timescale 1ns/100ps
`default_nettype none

module i_decode_top import decode_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   flush_i,
    input  word_t                 instr_i,
    input  word_t                 pc_i,
    input  wire                   i_queue_empty_i,
    output logic                  i_queue_read_o,
    input  word_t                 reg_vj_i,
    input  word_t                 reg_vk_i,
    input  rob_tag_t              reg_qj_i,
    input  rob_tag_t              reg_qk_i,
    output reg_idx_t              rs1_o,
    output reg_idx_t              rs2_o,
    output reg_idx_t              rd_o,
    output rob_tag_t              tag_o,
    output logic                  tag_load_o,
    input  rob_tag_t              rob_free_tag_i,
    input  wire                   rob_full_i,
    input  logic  [ROB_DEPTH-1:0] rob_ready_i,
    input  word_t [ROB_DEPTH-1:0] rob_value_i,
    output logic                  rob_write_o,
    output word_t                 rob_pc_o,
    output opcode_t               rob_opcode_o,
    output reg_idx_t              rob_rd_o,
    input  wire                   alu_rs_full_i,
    output logic                  alu_valid_o,
    output alu_op_t               alu_op_o,
    output operand_t              alu_src1_o,
    output operand_t              alu_src2_o,
    output rob_tag_t              alu_rob_tag_o,
    input  wire                   cmp_rs_full_i,
    output logic                  cmp_valid_o,
    output cmp_op_t               cmp_op_o,
    output logic                  cmp_is_branch_o,
    output operand_t              cmp_src1_o,
    output operand_t              cmp_src2_o,
    output word_t                 cmp_pc_o,
    output word_t                 cmp_b_imm_o,
    output rob_tag_t              cmp_rob_tag_o
);

    opcode_t  opcode;
    cmp_op_t  funct3;
    word_t    i_imm;
    word_t    u_imm;
    word_t    b_imm;
    station_t station;
    alu_op_t  alu_op;
    logic     use_rs1;
    logic     use_rs2;
    logic     is_branch;
    logic     accept;
    operand_t src1_reg;
    operand_t src2_reg;

    assign is_branch = (opcode == op_br);

    instr_fields u_fields (
        .instr_i   (instr_i),
        .opcode_o  (opcode),
        .funct3_o  (funct3),
        .rs1_o     (rs1_o),
        .rs2_o     (rs2_o),
        .rd_o      (rd_o),
        .i_imm_o   (i_imm),
        .u_imm_o   (u_imm),
        .b_imm_o   (b_imm),
        .station_o (station),
        .alu_op_o  (alu_op),
        .use_rs1_o (use_rs1),
        .use_rs2_o (use_rs2)
    );

    operand_fetch u_operands (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .accept_i    (accept),
        .is_branch_i (is_branch),
        .rs1_i       (rs1_o),
        .rs2_i       (rs2_o),
        .rd_i        (rd_o),
        .use_rs1_i   (use_rs1),
        .use_rs2_i   (use_rs2),
        .free_tag_i  (rob_free_tag_i),
        .reg_vj_i    (reg_vj_i),
        .reg_vk_i    (reg_vk_i),
        .reg_qj_i    (reg_qj_i),
        .reg_qk_i    (reg_qk_i),
        .rob_ready_i (rob_ready_i),
        .rob_value_i (rob_value_i),
        .src1_reg_o  (src1_reg),
        .src2_reg_o  (src2_reg)
    );

    issue_ctrl u_issue (
        .i_queue_empty_i (i_queue_empty_i),
        .flush_i         (flush_i),
        .station_i       (station),
        .is_branch_i     (is_branch),
        .rd_i            (rd_o),
        .free_tag_i      (rob_free_tag_i),
        .rob_full_i      (rob_full_i),
        .alu_rs_full_i   (alu_rs_full_i),
        .cmp_rs_full_i   (cmp_rs_full_i),
        .accept_o        (accept),
        .i_queue_read_o  (i_queue_read_o),
        .tag_load_o      (tag_load_o),
        .tag_o           (tag_o)
    );

    dispatch_regs u_dispatch (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .accept_i        (accept),
        .station_i       (station),
        .opcode_i        (opcode),
        .alu_op_i        (alu_op),
        .funct3_i        (funct3),
        .pc_i            (pc_i),
        .rd_i            (rd_o),
        .i_imm_i         (i_imm),
        .u_imm_i         (u_imm),
        .b_imm_i         (b_imm),
        .src1_reg_i      (src1_reg),
        .src2_reg_i      (src2_reg),
        .free_tag_i      (rob_free_tag_i),
        .alu_valid_o     (alu_valid_o),
        .alu_op_o        (alu_op_o),
        .alu_src1_o      (alu_src1_o),
        .alu_src2_o      (alu_src2_o),
        .alu_rob_tag_o   (alu_rob_tag_o),
        .cmp_valid_o     (cmp_valid_o),
        .cmp_op_o        (cmp_op_o),
        .cmp_is_branch_o (cmp_is_branch_o),
        .cmp_src1_o      (cmp_src1_o),
        .cmp_src2_o      (cmp_src2_o),
        .cmp_pc_o        (cmp_pc_o),
        .cmp_b_imm_o     (cmp_b_imm_o),
        .cmp_rob_tag_o   (cmp_rob_tag_o),
        .rob_write_o     (rob_write_o),
        .rob_pc_o        (rob_pc_o),
        .rob_opcode_o    (rob_opcode_o),
        .rob_rd_o        (rob_rd_o)
    );

endmodule

`default_nettype wire

/* src/dispatch_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module dispatch_regs import decode_pkg::*; (
    input  wire      clk,
    input  wire      rst_n_i,
    input  wire      flush_i,
    input  wire      accept_i,
    input  station_t station_i,
    input  opcode_t  opcode_i,
    input  alu_op_t  alu_op_i,
    input  cmp_op_t  funct3_i,
    input  word_t    pc_i,
    input  reg_idx_t rd_i,
    input  word_t    i_imm_i,
    input  word_t    u_imm_i,
    input  word_t    b_imm_i,
    input  operand_t src1_reg_i,
    input  operand_t src2_reg_i,
    input  rob_tag_t free_tag_i,
    output logic     alu_valid_o,
    output alu_op_t  alu_op_o,
    output operand_t alu_src1_o,
    output operand_t alu_src2_o,
    output rob_tag_t alu_rob_tag_o,
    output logic     cmp_valid_o,
    output cmp_op_t  cmp_op_o,
    output logic     cmp_is_branch_o,
    output operand_t cmp_src1_o,
    output operand_t cmp_src2_o,
    output word_t    cmp_pc_o,
    output word_t    cmp_b_imm_o,
    output rob_tag_t cmp_rob_tag_o,
    output logic     rob_write_o,
    output word_t    rob_pc_o,
    output opcode_t  rob_opcode_o,
    output reg_idx_t rob_rd_o
);

    operand_t src1;
    operand_t src2;
    logic     is_branch;
    logic     go_alu;
    logic     go_cmp;

    function automatic operand_t imm_operand(input word_t v);
        operand_t op;
        op.value = v;
        op.tag   = '0;
        op.ready = 1'b1;
        return op;
    endfunction

    assign is_branch = (opcode_i == op_br);
    assign go_alu    = accept_i && (station_i == st_alu);
    assign go_cmp    = accept_i && (station_i == st_cmp);

    // operand sources depend on the instruction form
    always_comb begin
        src1 = src1_reg_i;
        src2 = src2_reg_i;
        case (opcode_i)
            op_lui: begin
                src1 = imm_operand('0);
                src2 = imm_operand(u_imm_i);
            end
            op_auipc: begin
                src1 = imm_operand(pc_i);
                src2 = imm_operand(u_imm_i);
            end
            op_imm: begin
                src2 = imm_operand(i_imm_i);
            end
            default: begin
                src1 = src1_reg_i;
                src2 = src2_reg_i;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_valid_o <= 1'b0;
            cmp_valid_o <= 1'b0;
            rob_write_o <= 1'b0;
        end else if (flush_i) begin
            alu_valid_o <= 1'b0;
            cmp_valid_o <= 1'b0;
            rob_write_o <= 1'b0;
        end else begin
            alu_valid_o <= go_alu;
            cmp_valid_o <= go_cmp;
            rob_write_o <= accept_i;
        end
    end

    always_ff @(posedge clk) begin
        if (go_alu) begin
            alu_op_o      <= alu_op_i;
            alu_src1_o    <= src1;
            alu_src2_o    <= src2;
            alu_rob_tag_o <= free_tag_i;
        end
        if (go_cmp) begin
            cmp_op_o        <= funct3_i;
            cmp_is_branch_o <= is_branch;
            cmp_src1_o      <= src1;
            cmp_src2_o      <= src2;
            cmp_pc_o        <= pc_i;
            cmp_b_imm_o     <= is_branch ? b_imm_i : '0;
            cmp_rob_tag_o   <= free_tag_i;
        end
        if (accept_i) begin
            rob_pc_o     <= pc_i;
            rob_opcode_o <= opcode_i;
            // branch rd field holds immediate bits
            rob_rd_o     <= is_branch ? '0 : rd_i;
        end
    end

endmodule

`default_nettype wire

/* src/issue_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_ctrl import decode_pkg::*; (
    input  wire      i_queue_empty_i,
    input  wire      flush_i,
    input  station_t station_i,
    input  wire      is_branch_i,
    input  reg_idx_t rd_i,
    input  rob_tag_t free_tag_i,
    input  wire      rob_full_i,
    input  wire      alu_rs_full_i,
    input  wire      cmp_rs_full_i,
    output logic     accept_o,
    output logic     i_queue_read_o,
    output logic     tag_load_o,
    output rob_tag_t tag_o
);

    logic head_ok;
    logic target_ok;
    logic has_dest;
    logic discard;

    assign head_ok  = !i_queue_empty_i && !flush_i;
    assign has_dest = is_branch_i || (rd_i != '0);

    // only the station this instruction goes to can hold it back
    assign target_ok = (station_i == st_alu && !alu_rs_full_i) ||
                       (station_i == st_cmp && !cmp_rs_full_i);

    assign accept_o = head_ok && target_ok && has_dest &&
                      (free_tag_i != '0) && !rob_full_i;

    // writes to x0 and opcodes we do not handle are dropped
    assign discard = head_ok && (station_i == st_none || !has_dest);

    assign i_queue_read_o = accept_o || discard;

    // branches produce no register result
    assign tag_load_o = accept_o && !is_branch_i;
    assign tag_o      = tag_load_o ? free_tag_i : '0;

endmodule

`default_nettype wire

/* src/operand_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_fetch import decode_pkg::*; (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      flush_i,
    input  wire                      accept_i,
    input  wire                      is_branch_i,
    input  reg_idx_t                 rs1_i,
    input  reg_idx_t                 rs2_i,
    input  reg_idx_t                 rd_i,
    input  wire                      use_rs1_i,
    input  wire                      use_rs2_i,
    input  rob_tag_t                 free_tag_i,
    input  word_t                    reg_vj_i,
    input  word_t                    reg_vk_i,
    input  rob_tag_t                 reg_qj_i,
    input  rob_tag_t                 reg_qk_i,
    input  logic  [ROB_DEPTH-1:0]    rob_ready_i,
    input  word_t [ROB_DEPTH-1:0]    rob_value_i,
    output operand_t                 src1_reg_o,
    output operand_t                 src2_reg_o
);

    // rename made by the instruction accepted last cycle
    logic     prev_valid;
    reg_idx_t prev_rd;
    rob_tag_t prev_tag;

    reg_idx_t idx1;
    reg_idx_t idx2;

    function automatic operand_t resolve(input reg_idx_t idx, input word_t vreg,
                                         input rob_tag_t qreg);
        operand_t op;
        op.value = '0;
        op.tag   = '0;
        op.ready = 1'b1;
        if (idx == '0) begin
            op.ready = 1'b1;
        end else if (prev_valid && prev_rd == idx) begin
            // register file has not seen last cycle's rename yet
            op.tag   = prev_tag;
            op.ready = 1'b0;
        end else if (qreg != '0 && rob_ready_i[qreg]) begin
            op.value = rob_value_i[qreg];
        end else if (qreg != '0) begin
            op.tag   = qreg;
            op.ready = 1'b0;
        end else begin
            op.value = vreg;
        end
        return op;
    endfunction

    // immediate-sourced operands look like x0 here
    assign idx1 = use_rs1_i ? rs1_i : '0;
    assign idx2 = use_rs2_i ? rs2_i : '0;

    always_comb begin
        src1_reg_o = resolve(idx1, reg_vj_i, reg_qj_i);
        src2_reg_o = resolve(idx2, reg_vk_i, reg_qk_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_valid <= 1'b0;
        end else if (flush_i) begin
            prev_valid <= 1'b0;
        end else begin
            prev_valid <= accept_i && !is_branch_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i && !is_branch_i) begin
            prev_rd  <= rd_i;
            prev_tag <= free_tag_i;
        end
    end

endmodule

`default_nettype wire

/* src/instr_fields.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_fields import decode_pkg::*; (
    input  word_t    instr_i,
    output opcode_t  opcode_o,
    output cmp_op_t  funct3_o,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output reg_idx_t rd_o,
    output word_t    i_imm_o,
    output word_t    u_imm_o,
    output word_t    b_imm_o,
    output station_t station_o,
    output alu_op_t  alu_op_o,
    output logic     use_rs1_o,
    output logic     use_rs2_o
);

    logic    f7_bit5;
    logic    is_slt;
    cmp_op_t f3;

    assign opcode_o = opcode_t'(instr_i[6:0]);
    assign f3       = instr_i[14:12];
    assign funct3_o = f3;
    assign f7_bit5  = instr_i[30];
    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];
    assign rd_o     = instr_i[11:7];

    assign i_imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
    assign u_imm_o = {instr_i[31:12], 12'h000};
    assign b_imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    // slt and sltu go to the compare station in both forms
    assign is_slt = (f3 == F3_SLT) || (f3 == F3_SLTU);

    always_comb begin
        station_o = st_none;
        alu_op_o  = alu_add;
        use_rs1_o = 1'b0;
        use_rs2_o = 1'b0;
        case (opcode_o)
            op_lui, op_auipc: begin
                station_o = st_alu;
            end
            op_br: begin
                station_o = st_cmp;
                use_rs1_o = 1'b1;
                use_rs2_o = 1'b1;
            end
            op_imm: begin
                station_o = is_slt ? st_cmp : st_alu;
                use_rs1_o = 1'b1;
                // addi has no subtract form, only srai uses bit 30
                if (f3 == F3_SR) begin
                    alu_op_o = alu_op_t'({f7_bit5, f3});
                end else begin
                    alu_op_o = alu_op_t'({1'b0, f3});
                end
            end
            op_reg: begin
                station_o = is_slt ? st_cmp : st_alu;
                use_rs1_o = 1'b1;
                use_rs2_o = 1'b1;
                if (f3 == F3_SR || f3 == F3_ADD) begin
                    alu_op_o = alu_op_t'({f7_bit5, f3});
                end else begin
                    alu_op_o = alu_op_t'({1'b0, f3});
                end
            end
            default: begin
                station_o = st_none;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int ROB_DEPTH = 8;
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH);

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // tag 0 is reserved and means no producer
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // only the major opcodes this stage issues
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_op_t;

    // compare station reuses funct3 as its operation
    typedef logic [2:0] cmp_op_t;

    localparam cmp_op_t F3_ADD  = 3'b000;
    localparam cmp_op_t F3_SLT  = 3'b010;
    localparam cmp_op_t F3_SLTU = 3'b011;
    localparam cmp_op_t F3_SR   = 3'b101;

    typedef struct packed {
        word_t    value;
        rob_tag_t tag;
        logic     ready;
    } operand_t;

    typedef enum logic [1:0] {
        st_none = 2'd0,
        st_alu  = 2'd1,
        st_cmp  = 2'd2
    } station_t;

endpackage

`default_nettype wire
